// ==== verilog/axis_pkg.sv ====
package axis_pkg;

    // stream payload widths
    localparam int DATAW = 128;
    localparam int IDW   = 32;
    localparam int DESTW = 4;
    localparam int USERW = 32;

    // PE datapath splits each beat into 32-bit lanes
    localparam int LANEW  = 32;
    localparam int NLANES = 4;

    // switch geometry
    // ports 0..3 feed the PEs, port 4 is the master side
    localparam int NPORTS = 5;
    localparam int NPE    = 4;

    // destination index of the external output
    // anything above this has no port and is dropped at entry
    localparam int OUT_PORT = 4;

endpackage

// ==== verilog/axis_if.sv ====
`timescale 1ns/1ps

interface axis_if import axis_pkg::*; ();

    // valid/ready stream, beat moves when both are high on clk
    logic             tvalid;
    logic             tready;
    logic [DATAW-1:0] tdata;
    logic             tlast;
    logic [DESTW-1:0] tdest;
    // sequence number stamped by the master
    logic [USERW-1:0] tuser;

    // producer side
    modport source (
        output tvalid,
        output tdata,
        output tlast,
        output tdest,
        output tuser,
        input  tready
    );

    // consumer side
    modport sink (
        input  tvalid,
        input  tdata,
        input  tlast,
        input  tdest,
        input  tuser,
        output tready
    );

endinterface

// ==== verilog/master_module.sv ====
`timescale 1ns/1ps

module master_module import axis_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx_tvalid,
    input  logic             rx_tlast,
    output logic             rx_tready,
    input  logic [DATAW-1:0] rx_tdata,
    input  logic [DESTW-1:0] rx_tdest,
    axis_if.source           tx,
    output logic [15:0]      drop_count
);

    // framing state
    logic mid_pkt;
    logic drop_hold;
    logic drop_beat;
    logic tx_free;
    logic rx_fire;
    logic [USERW-1:0] seq_num;

    // drop decision taken on the first beat, held until tlast
    assign drop_beat = mid_pkt ? drop_hold : (rx_tdest > DESTW'(OUT_PORT));

    // single output register, free when empty or draining
    assign tx_free = ~tx.tvalid | tx.tready;

    // discarded beats are sunk without waiting on the switch
    assign rx_tready = drop_beat | tx_free;
    assign rx_fire   = rx_tvalid & rx_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            mid_pkt   <= 1'b0;
            drop_hold <= 1'b0;
        end else if (rx_fire) begin
            mid_pkt   <= ~rx_tlast;
            drop_hold <= drop_beat;
        end
    end

    // counters move once per packet, at tlast
    // dropped packets never take a sequence number
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_num    <= '0;
            drop_count <= '0;
        end else if (rx_fire && rx_tlast) begin
            if (drop_beat) begin
                drop_count <= drop_count + 16'd1;
            end else begin
                seq_num <= seq_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx.tvalid <= 1'b0;
        end else if (tx_free) begin
            tx.tvalid <= rx_tvalid & ~drop_beat;
        end
    end

    // payload, loaded only for forwarded beats
    always_ff @(posedge clk) begin
        if (tx_free && rx_tvalid && !drop_beat) begin
            tx.tdata <= rx_tdata;
            tx.tlast <= rx_tlast;
            tx.tdest <= rx_tdest;
            // whole packet carries the same number
            tx.tuser <= seq_num;
        end
    end

endmodule

// ==== verilog/wrapper_pe.sv ====
`timescale 1ns/1ps

module wrapper_pe import axis_pkg::*; #(
    parameter int PE_ID = 0
) (
    input  logic   clk,
    input  logic   rst,
    axis_if.sink   rx,
    axis_if.source tx
);

    logic             load;
    logic [DATAW-1:0] result;

    // one register stage, refills while draining
    assign load      = ~tx.tvalid | tx.tready;
    assign rx.tready = load;

    // per lane: x*3 + PE_ID, wraps at 32 bits
    always_comb begin
        for (int l = 0; l < NLANES; l++) begin
            result[l*LANEW +: LANEW] = rx.tdata[l*LANEW +: LANEW] * LANEW'(3)
                                     + LANEW'(PE_ID);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx.tvalid <= 1'b0;
        end else if (load) begin
            tx.tvalid <= rx.tvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && rx.tvalid) begin
            tx.tdata <= result;
            // framing and sequence number untouched
            tx.tlast <= rx.tlast;
            tx.tuser <= rx.tuser;
            // results always head for the external output
            tx.tdest <= DESTW'(OUT_PORT);
        end
    end

endmodule

// ==== verilog/axis_arbiter.sv ====
`timescale 1ns/1ps

module axis_arbiter import axis_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [NPORTS-1:0] request,
    input  logic              accept,
    input  logic              last,
    output logic [NPORTS-1:0] grant
);

    // search start point, one past the previous winner
    logic [$clog2(NPORTS)-1:0] prio;
    logic [$clog2(NPORTS)-1:0] win_idx;
    logic [$clog2(NPORTS)-1:0] next_prio;
    logic [NPORTS-1:0]         pick;
    logic [NPORTS-1:0]         grant_q;
    logic                      locked;

    // round robin pick
    // scan from farthest to nearest so the nearest requester wins
    always_comb begin
        int idx;
        pick    = '0;
        win_idx = '0;
        for (int k = NPORTS - 1; k >= 0; k--) begin
            idx = int'(prio) + k;
            if (idx >= NPORTS) begin
                idx = idx - NPORTS;
            end
            if (request[idx]) begin
                pick      = '0;
                pick[idx] = 1'b1;
                win_idx   = idx[$clog2(NPORTS)-1:0];
            end
        end
    end

    assign next_prio = (int'(win_idx) == NPORTS - 1) ? '0 : win_idx + 1'b1;

    // mid packet the old grant holds even if its source idles
    assign grant = locked ? grant_q : pick;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio    <= '0;
            grant_q <= '0;
            locked  <= 1'b0;
        end else if (accept) begin
            // first beat of a packet fixes the winner
            if (!locked) begin
                prio    <= next_prio;
                grant_q <= pick;
            end
            // released by the tlast beat
            locked <= ~last;
        end
    end

endmodule

// ==== verilog/axis_switch_wrap_5x5.sv ====
`timescale 1ns/1ps

module axis_switch_wrap_5x5 import axis_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    axis_if.sink             s00,
    axis_if.sink             s01,
    axis_if.sink             s02,
    axis_if.sink             s03,
    axis_if.sink             s04,
    axis_if.source           m00,
    axis_if.source           m01,
    axis_if.source           m02,
    axis_if.source           m03,
    output logic             m04_tvalid,
    input  logic             m04_tready,
    output logic [DATAW-1:0] m04_tdata,
    output logic             m04_tlast,
    output logic [IDW-1:0]   m04_tid,
    output logic [DESTW-1:0] m04_tdest,
    output logic [USERW-1:0] m04_tuser
);

    // inputs flattened by port index
    logic [NPORTS-1:0]            in_valid;
    logic [NPORTS-1:0]            in_last;
    logic [NPORTS-1:0]            in_ready;
    logic [NPORTS-1:0][DATAW-1:0] in_data;
    logic [NPORTS-1:0][DESTW-1:0] in_dest;
    logic [NPORTS-1:0][USERW-1:0] in_user;

    // crossbar control, [output][input]
    logic [NPORTS-1:0][NPORTS-1:0] dest_hit;
    logic [NPORTS-1:0][NPORTS-1:0] req;
    logic [NPORTS-1:0][NPORTS-1:0] grant;

    // per output
    logic [NPORTS-1:0]            out_ready;
    logic [NPORTS-1:0]            out_load;
    logic [NPORTS-1:0]            out_take;
    logic [NPORTS-1:0][DATAW-1:0] sel_data;
    logic [NPORTS-1:0]            sel_last;
    logic [NPORTS-1:0][DESTW-1:0] sel_dest;
    logic [NPORTS-1:0][USERW-1:0] sel_user;
    logic [IDW-1:0]               sel_id;

    // output registers, tid only exists on the external port
    logic [NPORTS-1:0]            out_valid;
    logic [NPORTS-1:0][DATAW-1:0] out_data;
    logic [NPORTS-1:0]            out_last;
    logic [NPORTS-1:0][DESTW-1:0] out_dest;
    logic [NPORTS-1:0][USERW-1:0] out_user;
    logic [IDW-1:0]               out_id;

    assign in_valid = {s04.tvalid, s03.tvalid, s02.tvalid, s01.tvalid, s00.tvalid};
    assign in_last  = {s04.tlast, s03.tlast, s02.tlast, s01.tlast, s00.tlast};
    assign in_data  = {s04.tdata, s03.tdata, s02.tdata, s01.tdata, s00.tdata};
    assign in_dest  = {s04.tdest, s03.tdest, s02.tdest, s01.tdest, s00.tdest};
    assign in_user  = {s04.tuser, s03.tuser, s02.tuser, s01.tuser, s00.tuser};

    assign s00.tready = in_ready[0];
    assign s01.tready = in_ready[1];
    assign s02.tready = in_ready[2];
    assign s03.tready = in_ready[3];
    assign s04.tready = in_ready[4];

    assign out_ready = {m04_tready, m03.tready, m02.tready, m01.tready, m00.tready};

    // destination decode
    // a tdest with no port raises no request and the input waits
    always_comb begin
        for (int o = 0; o < NPORTS; o++) begin
            for (int i = 0; i < NPORTS; i++) begin
                dest_hit[o][i] = (in_dest[i] == DESTW'(o));
            end
            req[o] = in_valid & dest_hit[o];
        end
    end

    // output register takes a beat when empty or draining
    assign out_load = ~out_valid | out_ready;

    for (genvar o = 0; o < NPORTS; o++) begin : g_arb
        axis_arbiter u_arb (
            .clk     (clk),
            .rst     (rst),
            .request (req[o]),
            .accept  (out_load[o] & out_take[o]),
            .last    (sel_last[o]),
            .grant   (grant[o])
        );
    end

    // grant driven mux and ready fan-back
    always_comb begin
        in_ready = '0;
        sel_id   = '0;
        for (int o = 0; o < NPORTS; o++) begin
            out_take[o] = |(grant[o] & req[o]);
            sel_data[o] = '0;
            sel_last[o] = 1'b0;
            sel_dest[o] = '0;
            sel_user[o] = '0;
            for (int i = 0; i < NPORTS; i++) begin
                if (grant[o][i]) begin
                    sel_data[o] = in_data[i];
                    sel_last[o] = in_last[i];
                    sel_dest[o] = in_dest[i];
                    sel_user[o] = in_user[i];
                end
                // input moves only into its granted, free output
                if (grant[o][i] && dest_hit[o][i] && out_load[o]) begin
                    in_ready[i] = 1'b1;
                end
            end
        end
        // source port number becomes tid
        for (int i = 0; i < NPORTS; i++) begin
            if (grant[OUT_PORT][i]) begin
                sel_id = IDW'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            for (int o = 0; o < NPORTS; o++) begin
                if (out_load[o]) begin
                    out_valid[o] <= out_take[o];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NPORTS; o++) begin
            if (out_load[o] && out_take[o]) begin
                out_data[o] <= sel_data[o];
                out_last[o] <= sel_last[o];
                out_dest[o] <= sel_dest[o];
                out_user[o] <= sel_user[o];
            end
        end
        if (out_load[OUT_PORT] && out_take[OUT_PORT]) begin
            out_id <= sel_id;
        end
    end

    // PE-facing outputs
    assign m00.tvalid = out_valid[0];
    assign m00.tdata  = out_data[0];
    assign m00.tlast  = out_last[0];
    assign m00.tdest  = out_dest[0];
    assign m00.tuser  = out_user[0];
    assign m01.tvalid = out_valid[1];
    assign m01.tdata  = out_data[1];
    assign m01.tlast  = out_last[1];
    assign m01.tdest  = out_dest[1];
    assign m01.tuser  = out_user[1];
    assign m02.tvalid = out_valid[2];
    assign m02.tdata  = out_data[2];
    assign m02.tlast  = out_last[2];
    assign m02.tdest  = out_dest[2];
    assign m02.tuser  = out_user[2];
    assign m03.tvalid = out_valid[3];
    assign m03.tdata  = out_data[3];
    assign m03.tlast  = out_last[3];
    assign m03.tdest  = out_dest[3];
    assign m03.tuser  = out_user[3];

    // external output
    assign m04_tvalid = out_valid[OUT_PORT];
    assign m04_tdata  = out_data[OUT_PORT];
    assign m04_tlast  = out_last[OUT_PORT];
    assign m04_tid    = out_id;
    assign m04_tdest  = out_dest[OUT_PORT];
    assign m04_tuser  = out_user[OUT_PORT];

endmodule

// ==== verilog/axis_switch_loaded.sv ====
`timescale 1ns/1ps

module axis_switch_loaded import axis_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             s_tvalid,
    output logic             s_tready,
    input  logic [DATAW-1:0] s_tdata,
    input  logic             s_tlast,
    input  logic [DESTW-1:0] s_tdest,
    output logic             m_tvalid,
    input  logic             m_tready,
    output logic [DATAW-1:0] m_tdata,
    output logic             m_tlast,
    output logic [IDW-1:0]   m_tid,
    output logic [USERW-1:0] m_tuser,
    output logic [DESTW-1:0] m_tdest,
    output logic [15:0]      drop_count
);

    // master into switch port 4
    axis_if mst_to_sw ();
    // switch outputs 0..3 into the PEs
    axis_if sw_to_pe [NPE] ();
    // PE results back into switch inputs 0..3
    axis_if pe_to_sw [NPE] ();

    master_module u_master (
        .clk        (clk),
        .rst        (rst),
        .rx_tvalid  (s_tvalid),
        .rx_tlast   (s_tlast),
        .rx_tready  (s_tready),
        .rx_tdata   (s_tdata),
        .rx_tdest   (s_tdest),
        .tx         (mst_to_sw),
        .drop_count (drop_count)
    );

    // PE index doubles as its switch port
    for (genvar p = 0; p < NPE; p++) begin : g_pe
        wrapper_pe #(
            .PE_ID (p)
        ) u_pe (
            .clk (clk),
            .rst (rst),
            .rx  (sw_to_pe[p]),
            .tx  (pe_to_sw[p])
        );
    end

    axis_switch_wrap_5x5 u_switch (
        .clk        (clk),
        .rst        (rst),
        .s00        (pe_to_sw[0]),
        .s01        (pe_to_sw[1]),
        .s02        (pe_to_sw[2]),
        .s03        (pe_to_sw[3]),
        .s04        (mst_to_sw),
        .m00        (sw_to_pe[0]),
        .m01        (sw_to_pe[1]),
        .m02        (sw_to_pe[2]),
        .m03        (sw_to_pe[3]),
        .m04_tvalid (m_tvalid),
        .m04_tready (m_tready),
        .m04_tdata  (m_tdata),
        .m04_tlast  (m_tlast),
        .m04_tid    (m_tid),
        .m04_tdest  (m_tdest),
        .m04_tuser  (m_tuser)
    );

endmodule

// ==== dv/axis_switch_chk.sv ====
`timescale 1ns/1ps

module axis_switch_chk import axis_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             s_tvalid,
    input logic             m_tvalid,
    input logic             m_tready,
    input logic [DATAW-1:0] m_tdata,
    input logic             m_tlast,
    input logic [IDW-1:0]   m_tid,
    input logic [USERW-1:0] m_tuser,
    input logic [DESTW-1:0] m_tdest
);

    // read back by the testbench at the end of the run
    int assert_fails = 0;

    // both ends idle on the first cycle out of reset
    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !m_tvalid && !s_tvalid)
        else begin
            $error("valid high on the first cycle after reset");
            assert_fails++;
        end

    // stalled beat held until taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
            && $stable(m_tid) && $stable(m_tuser) && $stable(m_tdest))
        else begin
            $error("output beat changed while stalled");
            assert_fails++;
        end

    // everything leaving the cluster is addressed to the output port
    dest_fixed: assert property (@(posedge clk) disable iff (rst)
        m_tvalid |-> m_tdest == DESTW'(OUT_PORT))
        else begin
            $error("m_tdest is not the output port");
            assert_fails++;
        end

endmodule

bind axis_switch_loaded axis_switch_chk u_axis_chk (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tlast  (m_tlast),
    .m_tid    (m_tid),
    .m_tuser  (m_tuser),
    .m_tdest  (m_tdest)
);

// ==== dv/tb_axis_switch_loaded.sv ====
`timescale 1ns/1ps

module tb_axis_switch_loaded import axis_pkg::*; ();

    // beats driven over the whole run, sets the watchdog limit
    // pe 4, bypass 4, drops 17 plus 4 valid, bursts 20, stalled run up to 60
    localparam int PLANNED_BEATS  = 109;
    localparam int TIMEOUT_CYCLES = PLANNED_BEATS * 50 + 1000;

    logic             clk;
    logic             rst;
    logic             s_tvalid;
    logic             s_tready;
    logic [DATAW-1:0] s_tdata;
    logic             s_tlast;
    logic [DESTW-1:0] s_tdest;
    logic             m_tvalid;
    logic             m_tready;
    logic [DATAW-1:0] m_tdata;
    logic             m_tlast;
    logic [IDW-1:0]   m_tid;
    logic [USERW-1:0] m_tuser;
    logic [DESTW-1:0] m_tdest;
    logic [15:0]      drop_count;

    int errors       = 0;
    int fails        = 0;
    // model of the master's sequence counter
    int next_seq     = 0;
    int exp_drops    = 0;
    int exp_total    = 0;
    int rx_total     = 0;
    int open_seq     = -1;
    bit stall_output = 0;

    // expected packets by sequence number, data keyed seq*16 + beat
    logic [DATAW-1:0] sent_data [int];
    int               pkt_dest  [int];
    int               pkt_len   [int];
    int               pkt_got   [int];

    // beats seen on the external output
    logic [DATAW-1:0] q_data [$];
    logic             q_last [$];
    logic [IDW-1:0]   q_tid  [$];
    logic [USERW-1:0] q_user [$];
    logic [DESTW-1:0] q_dest [$];

    axis_switch_loaded UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random stalls on the output, only while enabled
    initial begin
        forever begin
            @(negedge clk);
            m_tready = stall_output ? ($urandom % 2 == 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && m_tvalid && m_tready) begin
            q_data.push_back(m_tdata);
            q_last.push_back(m_tlast);
            q_tid.push_back(m_tid);
            q_user.push_back(m_tuser);
            q_dest.push_back(m_tdest);
            rx_total++;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, output never finished",
                 TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [DATAW-1:0] expected,
                               input logic [DATAW-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // PE rule: each lane times three plus the PE index, bypass unchanged
    function automatic logic [DATAW-1:0] expected_result(input int dest,
                                                         input logic [DATAW-1:0] data);
        logic [DATAW-1:0] res;
        logic [LANEW-1:0] lane;
        res = data;
        if (dest != OUT_PORT) begin
            for (int l = 0; l < NLANES; l++) begin
                lane = data[l*LANEW +: LANEW];
                res[l*LANEW +: LANEW] = lane * 32'd3 + LANEW'(dest);
            end
        end
        return res;
    endfunction

    // called on a falling edge, returns on one
    task automatic send_packet(input int dest, input int nbeats);
        logic [DATAW-1:0] data;
        bit               keep;
        keep = (dest <= OUT_PORT);
        if (keep) begin
            pkt_dest[next_seq] = dest;
            pkt_len[next_seq]  = nbeats;
            pkt_got[next_seq]  = 0;
        end
        for (int b = 0; b < nbeats; b++) begin
            data = {$urandom, $urandom, $urandom, $urandom};
            if (keep) begin
                sent_data[next_seq * 16 + b] = data;
            end
            s_tvalid = 1'b1;
            s_tdata  = data;
            s_tlast  = (b == nbeats - 1);
            s_tdest  = DESTW'(dest);
            @(posedge clk);
            while (!s_tready) @(posedge clk);
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        // dropped packets take no sequence number
        if (keep) begin
            next_seq++;
            exp_total += nbeats;
        end else begin
            exp_drops++;
        end
    endtask

    task automatic check_received();
        logic [DATAW-1:0] data;
        logic             last;
        logic [IDW-1:0]   tid;
        logic [DESTW-1:0] dest;
        int               seq;
        int               pos;
        while (q_data.size() > 0) begin
            data = q_data.pop_front();
            last = q_last.pop_front();
            tid  = q_tid.pop_front();
            dest = q_dest.pop_front();
            seq  = int'(q_user.pop_front());
            if (!pkt_len.exists(seq)) begin
                errors++;
                $display("ERROR: output beat carries unknown sequence number %0d", seq);
            end else begin
                // output arbiter holds a packet until tlast
                if (open_seq >= 0 && seq != open_seq) begin
                    errors++;
                    $display("ERROR: packet %0d cut into packet %0d", seq, open_seq);
                end
                pos = pkt_got[seq];
                if (pos >= pkt_len[seq]) begin
                    errors++;
                    $display("ERROR: packet %0d returned more beats than sent", seq);
                end else begin
                    check_value("m_tdata", expected_result(pkt_dest[seq],
                                sent_data[seq * 16 + pos]), data);
                    check_value("m_tlast", DATAW'(pos == pkt_len[seq] - 1), DATAW'(last));
                    check_value("m_tid", DATAW'(pkt_dest[seq]), DATAW'(tid));
                    check_value("m_tdest", DATAW'(OUT_PORT), DATAW'(dest));
                    pkt_got[seq] = pos + 1;
                end
                open_seq = last ? -1 : seq;
            end
        end
    endtask

    // wait for all expected beats, settle, then score
    task automatic wait_and_check(input int first_seq);
        while (rx_total < exp_total) @(negedge clk);
        repeat (20) @(negedge clk);
        check_received();
        for (int s = first_seq; s < next_seq; s++) begin
            if (pkt_got[s] != pkt_len[s]) begin
                errors++;
                $display("ERROR: packet %0d returned %0d of %0d beats",
                         s, pkt_got[s], pkt_len[s]);
            end
        end
        check_value("output beat count", DATAW'(exp_total), DATAW'(rx_total));
        check_value("drop_count", DATAW'(exp_drops), DATAW'(drop_count));
    endtask

    task automatic route_to_pes();
        int first;
        first = next_seq;
        for (int d = 0; d < NPE; d++) begin
            send_packet(d, 1);
        end
        wait_and_check(first);
    endtask

    task automatic bypass_to_output();
        int first;
        first = next_seq;
        send_packet(OUT_PORT, 1);
        send_packet(OUT_PORT, 3);
        wait_and_check(first);
    endtask

    // bad destinations between good ones, numbering must not skip
    task automatic drop_bad_dests();
        int first;
        first = next_seq;
        send_packet(1, 1);
        for (int d = OUT_PORT + 1; d < 16; d++) begin
            send_packet(d, 1 + d % 2);
        end
        send_packet(2, 2);
        send_packet(OUT_PORT, 1);
        wait_and_check(first);
    endtask

    task automatic send_burst_packets();
        int first;
        first = next_seq;
        for (int d = 0; d <= OUT_PORT; d++) begin
            send_packet(d, 4);
        end
        wait_and_check(first);
    endtask

    task automatic stall_output_randomly();
        int first;
        first = next_seq;
        stall_output = 1'b1;
        for (int p = 0; p < 20; p++) begin
            send_packet(int'($urandom % NPORTS), 1 + int'($urandom % 3));
        end
        wait_and_check(first);
        stall_output = 1'b0;
    endtask

    initial begin
        void'($urandom(26695));
        rst      = 1'b1;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tlast  = 1'b0;
        s_tdest  = '0;
        m_tready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        route_to_pes();
        bypass_to_output();
        drop_bad_dests();
        send_burst_packets();
        stall_output_randomly();

        fails = UUT.u_axis_chk.assert_fails;
        $display("run complete: %0d check errors, %0d assertion failures, %0d beats received",
                 errors, fails, rx_total);
        if (errors == 0 && fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/axis_pkg.sv
verilog/axis_if.sv
verilog/master_module.sv
verilog/wrapper_pe.sv
verilog/axis_arbiter.sv
verilog/axis_switch_wrap_5x5.sv
verilog/axis_switch_loaded.sv
dv/axis_switch_chk.sv
dv/tb_axis_switch_loaded.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cluster testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axis_switch_loaded -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# raised error limit lets assertion failures reach the final report
output=$(./obj_dir/sim_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
